//--- filelist.f
common/div_op_pkg.sv
common/div_data_pkg.sv
divider/div_operand_prep.sv
divider/div_restoring_core.sv
divider/div_result_fixup.sv
logic/div_unit_top.sv
testbench/div_ref_model.sv
testbench/tb_div_unit.sv

//--- Bender.yml
package:
  name: div_unit

sources:
  - common/div_op_pkg.sv
  - common/div_data_pkg.sv
  - divider/div_operand_prep.sv
  - divider/div_restoring_core.sv
  - divider/div_result_fixup.sv
  - logic/div_unit_top.sv
  - target: test
    files:
      - testbench/div_ref_model.sv
      - testbench/tb_div_unit.sv

//--- testbench/tb_div_unit.sv
// rst_n is active high here; every handshake wait gives up after 200 cycles
`timescale 1ns/1ns

module tb_div_unit
  import div_op_pkg::*;
  import div_data_pkg::*;
  import div_ref_model::*;
;

  localparam int TIMEOUT = 200;

  logic            clk;
  logic            rst_n;
  logic            req_valid;
  logic            req_ready;
  div_req_t        req;
  logic            resp_valid;
  logic            resp_ready;
  logic [XLEN-1:0] resp_data;
  int              seed;
  int              errors;
  int              timeouts;

  div_unit_top dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid),
    .req_ready_o  (req_ready),
    .req_i        (req),
    .resp_valid_o (resp_valid),
    .resp_ready_i (resp_ready),
    .resp_data_o  (resp_data)
  );

  always #10 clk = ~clk;   // 20 ns period

  // ==============================
  // one request, response held for hold cycles
  // ==============================
  task automatic run_op(input div_op_e op, input logic [XLEN-1:0] a,
                        input logic [XLEN-1:0] b, input string name, input int hold);
    logic [XLEN-1:0] exp;
    logic [XLEN-1:0] held;
    int              lat;
    int              cycles;
    exp = ref_result(op, a, b);
    lat = ref_latency(op, a, b);
    cycles = 0;
    while (!req_ready && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!req_ready) begin
      $display("timeout: unit never became ready for %s", name);
      timeouts++;
      return;
    end
    req_valid    = 1'b1;
    req.op       = op;
    req.dividend = a;
    req.divisor  = b;
    @(negedge clk);                      // accepting edge has passed
    req_valid = 1'b0;
    cycles = 1;
    while (!resp_valid && cycles < TIMEOUT) begin
      assert (!req_ready) else begin
        $display("unit accepted a new request while %s was in flight", name);
        errors++;
      end
      @(negedge clk);
      cycles++;
    end
    if (!resp_valid) begin
      $display("timeout: no response for %s", name);
      timeouts++;
      return;
    end
    assert (cycles == lat) else begin
      $display("ERR %s latency: expected %0d, actual %0d", name, lat, cycles);
      errors++;
    end
    assert (resp_data == exp) else begin
      $display("ERR %s: expected %h, actual %h", name, exp, resp_data);
      errors++;
    end
    assert (!req_ready) else begin
      $display("unit ready while the response to %s was pending", name);
      errors++;
    end
    held = resp_data;
    repeat (hold) begin
      @(negedge clk);
      assert (resp_valid && resp_data == held) else begin
        $display("ERR %s held response: expected %h, actual %h", name, held, resp_data);
        errors++;
      end
      assert (!req_ready) else begin
        $display("unit ready while the response to %s was held back", name);
        errors++;
      end
    end
    resp_ready = 1'b1;
    @(negedge clk);                      // transfer edge
    resp_ready = 1'b0;
    assert (req_ready && !resp_valid) else begin
      $display("unit did not return to idle after the response to %s", name);
      errors++;
    end
  endtask

  initial begin
    div_op_e         op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [31:0]     r;
    seed       = 32'h3f7b;
    errors     = 0;
    timeouts   = 0;
    clk        = 1'b0;
    rst_n      = 1'b1;                   // reset asserted
    req_valid  = 1'b0;
    req        = '0;
    resp_ready = 1'b0;
    repeat (8) @(negedge clk);
    rst_n = 1'b0;
    @(negedge clk);
    assert (!resp_valid && req_ready) else begin
      $display("unit not idle after reset");
      errors++;
    end

    // ==============================
    // special cases
    // ==============================
    for (int i = 0; i < 8; i++) begin
      op = div_op_e'(i);
      a  = {$random(seed), $random(seed)};
      run_op(op, a, '0, $sformatf("divzero %s", op.name()), {$random(seed)} % 11);
    end
    run_op(OP_DIV, 64'h8000_0000_0000_0000, '1, "overflow OP_DIV", 0);
    run_op(OP_REM, 64'h8000_0000_0000_0000, '1, "overflow OP_REM", 3);
    run_op(OP_DIVW, 64'h1234_5678_8000_0000, 64'h0000_0000_ffff_ffff, "overflow OP_DIVW", 0);
    run_op(OP_REMW, 64'hffff_ffff_8000_0000, '1, "overflow OP_REMW", 2);

    // random ops, some with small divisors
    for (int n = 0; n < 400; n++) begin
      r  = $random(seed);
      op = div_op_e'(r[2:0]);
      a  = {$random(seed), $random(seed)};
      b  = {$random(seed), $random(seed)};
      if (r[4:3] == 2'b00) b = {{(XLEN-8){r[15]}}, r[15:8]};
      run_op(op, a, b, $sformatf("random %0d %s", n, op.name()), {$random(seed)} % 11);
    end

    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- testbench/div_ref_model.sv
// reference rules for the eight divide ops; only the enum and the widths come from the design
package div_ref_model;
  import div_op_pkg::*;
  import div_data_pkg::*;

  function automatic bit op_is_word(div_op_e op);
    return op inside {OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
  endfunction

  function automatic bit op_is_rem(div_op_e op);
    return op inside {OP_REM, OP_REMW, OP_REMU, OP_REMUW};
  endfunction

  function automatic bit op_is_signed(div_op_e op);
    return op inside {OP_DIV, OP_DIVW, OP_REM, OP_REMW};
  endfunction

  // zero divisor, or most negative value over minus one
  function automatic bit ref_special(div_op_e op, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
    if (op_is_word(op)) begin
      return (b[WLEN-1:0] == '0) ||
             (op_is_signed(op) && a[WLEN-1:0] == 32'h8000_0000 && &b[WLEN-1:0]);
    end
    return (b == '0) || (op_is_signed(op) && a == {1'b1, {(XLEN-1){1'b0}}} && &b);
  endfunction

  // cycles from accepting edge to resp valid
  function automatic int ref_latency(div_op_e op, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
    if (ref_special(op, a, b)) return 1;
    return op_is_word(op) ? WLEN + 1 : XLEN + 1;
  endfunction

  function automatic logic [XLEN-1:0] ref_result(div_op_e op, logic [XLEN-1:0] a,
                                                 logic [XLEN-1:0] b);
    logic signed [WLEN-1:0] sa32;
    logic signed [WLEN-1:0] sb32;
    logic signed [XLEN-1:0] sa64;
    logic signed [XLEN-1:0] sb64;
    logic [WLEN-1:0]        w;
    logic [XLEN-1:0]        d;
    sa32 = a[WLEN-1:0];
    sb32 = b[WLEN-1:0];
    sa64 = a;
    sb64 = b;
    if (op_is_word(op)) begin
      if (b[WLEN-1:0] == '0) w = op_is_rem(op) ? a[WLEN-1:0] : '1;
      else if (ref_special(op, a, b)) w = op_is_rem(op) ? '0 : a[WLEN-1:0];
      else if (op_is_signed(op)) w = op_is_rem(op) ? sa32 % sb32 : sa32 / sb32;
      else w = op_is_rem(op) ? a[WLEN-1:0] % b[WLEN-1:0] : a[WLEN-1:0] / b[WLEN-1:0];
      return {{(XLEN-WLEN){w[WLEN-1]}}, w};   // word results sign-extend
    end
    if (b == '0) d = op_is_rem(op) ? a : '1;
    else if (ref_special(op, a, b)) d = op_is_rem(op) ? '0 : a;
    else if (op_is_signed(op)) d = op_is_rem(op) ? sa64 % sb64 : sa64 / sb64;
    else d = op_is_rem(op) ? a % b : a / b;
    return d;
  endfunction

endpackage

//--- logic/div_unit_top.sv
// single outstanding op; req_i must stay stable while req_valid_i is high
`timescale 1ns/1ns

module div_unit_top
  import div_data_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            req_valid_i,
  output logic            req_ready_o,
  input  div_req_t        req_i,
  output logic            resp_valid_o,
  input  logic            resp_ready_i,
  output logic [XLEN-1:0] resp_data_o
);

  div_prep_t   prep;     // operands in loop form
  div_result_t result;   // magnitudes plus sign info

  div_operand_prep u_prep (
    .req_i  (req_i),
    .prep_o (prep)
  );

  // core gates start with its own IDLE
  div_restoring_core u_core (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (req_valid_i),
    .prep_i       (prep),
    .ready_o      (req_ready_o),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .result_o     (result)
  );

  div_result_fixup u_fixup (
    .result_i (result),
    .data_o   (resp_data_o)
  );

endmodule

//--- divider/div_result_fixup.sv
// combinational; result_i is only meaningful while the core holds its response
`timescale 1ns/1ns

module div_result_fixup
  import div_data_pkg::*;
(
  input  div_result_t     result_i,
  output logic [XLEN-1:0] data_o
);

  logic [XLEN-1:0] quotient;
  logic [XLEN-1:0] remainder;
  logic [XLEN-1:0] selected;

  // ==============================
  // sign restore
  // ==============================
  assign quotient  = result_i.q_neg ? -result_i.quotient_mag : result_i.quotient_mag;
  assign remainder = result_i.r_neg ? -result_i.remainder_mag : result_i.remainder_mag;

  assign selected = result_i.attr.is_rem ? remainder : quotient;

  always_comb begin
    if (result_i.special) begin
      data_o = result_i.special_value;   // already in final form
    end else if (result_i.attr.is_word) begin
      // low word of the 64-bit negate is the 32-bit result
      data_o = {{(XLEN-WLEN){selected[WLEN-1]}}, selected[WLEN-1:0]};
    end else begin
      data_o = selected;
    end
  end

endmodule

//--- divider/div_restoring_core.sv
// one op in flight; start_i is taken only in IDLE and prep_i is sampled on that same edge
`timescale 1ns/1ns

module div_restoring_core
  import div_op_pkg::*;
  import div_data_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start_i,
  input  div_prep_t   prep_i,
  output logic        ready_o,
  output logic        resp_valid_o,
  input  logic        resp_ready_i,
  output div_result_t result_o
);

  div_state_e        state;
  div_state_e        next_state;
  logic [6:0]        cnt;               // steps left
  logic [2*XLEN-1:0] acc;               // remainder high, dividend/quotient low
  logic [XLEN-1:0]   divisor;
  logic [XLEN:0]     diff;              // trial subtract, msb is borrow
  logic              accept;
  div_attr_t         attr_q;
  logic              q_neg_q;
  logic              r_neg_q;
  logic              special_q;
  logic [XLEN-1:0]   special_value_q;

  assign accept = start_i && (state == IDLE);

  // shifted partial remainder is acc[127:63]
  assign diff = acc[2*XLEN-1:XLEN-1] - {1'b0, divisor};

  // ==============================
  // control
  // ==============================
  always_comb begin
    next_state = state;
    case (state)
      IDLE:    if (start_i) next_state = prep_i.special ? DONE : ITERATE;
      ITERATE: if (cnt == 7'd1) next_state = DONE;   // last step this cycle
      DONE:    if (resp_ready_i) next_state = IDLE;
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state <= IDLE;
      cnt   <= '0;
    end else begin
      state <= next_state;
      if (accept) begin
        cnt <= prep_i.attr.is_word ? 7'(WLEN) : 7'(XLEN);
      end else if (state == ITERATE) begin
        cnt <= cnt - 7'd1;
      end
    end
  end

  // ==============================
  // datapath
  // ==============================
  always_ff @(posedge clk) begin
    if (accept) begin
      attr_q          <= prep_i.attr;
      q_neg_q         <= prep_i.q_neg;
      r_neg_q         <= prep_i.r_neg;
      special_q       <= prep_i.special;
      special_value_q <= prep_i.special_value;
      divisor         <= prep_i.divisor_abs;
      // word dividend sits at the top of the low half, 32 steps move it up
      if (prep_i.attr.is_word) begin
        acc <= {{XLEN{1'b0}}, prep_i.dividend_abs[WLEN-1:0], {WLEN{1'b0}}};
      end else begin
        acc <= {{XLEN{1'b0}}, prep_i.dividend_abs};
      end
    end else if (state == ITERATE) begin
      if (diff[XLEN]) begin
        acc <= {acc[2*XLEN-2:0], 1'b0};                     // restore
      end else begin
        acc <= {diff[XLEN-1:0], acc[XLEN-2:0], 1'b1};
      end
    end
  end

  assign ready_o      = (state == IDLE);
  assign resp_valid_o = (state == DONE);

  always_comb begin
    result_o.attr          = attr_q;
    result_o.quotient_mag  = attr_q.is_word ? {{(XLEN-WLEN){1'b0}}, acc[WLEN-1:0]} :
                                              acc[XLEN-1:0];
    result_o.remainder_mag = acc[2*XLEN-1:XLEN];
    result_o.q_neg         = q_neg_q;
    result_o.r_neg         = r_neg_q;
    result_o.special       = special_q;
    result_o.special_value = special_value_q;
  end

  // ==============================
  // checks
  // ==============================
  // a loop result is only offered once every step has run
  a_steps_done: assert property (@(posedge clk) disable iff (rst_n)
    (resp_valid_o && !special_q) |-> cnt == '0);

  a_cnt_nonzero: assert property (@(posedge clk) disable iff (rst_n)
    state == ITERATE |-> cnt != '0);

  a_resp_held: assert property (@(posedge clk) disable iff (rst_n)
    (resp_valid_o && !resp_ready_i) |=> resp_valid_o && $stable(result_o));

endmodule

//--- divider/div_operand_prep.sv
// purely combinational; req_i must be stable for the whole cycle the core samples it
`timescale 1ns/1ns

module div_operand_prep
  import div_op_pkg::*;
  import div_data_pkg::*;
(
  input  div_req_t  req_i,
  output div_prep_t prep_o
);

  div_attr_t       attr;
  logic [XLEN-1:0] dvd_sext;    // word forms sign-extended
  logic [XLEN-1:0] dvs_sext;
  logic [XLEN-1:0] dvd_ext;     // value the loop divides
  logic [XLEN-1:0] dvs_ext;
  logic [XLEN-1:0] min_neg;     // most negative value of the form
  logic            dvd_neg;
  logic            dvs_neg;
  logic            div_zero;
  logic            overflow;

  assign attr = decode_op(req_i.op);

  // ==============================
  // operand forms
  // ==============================
  assign dvd_sext = attr.is_word ?
                    {{(XLEN-WLEN){req_i.dividend[WLEN-1]}}, req_i.dividend[WLEN-1:0]} :
                    req_i.dividend;
  assign dvs_sext = attr.is_word ?
                    {{(XLEN-WLEN){req_i.divisor[WLEN-1]}}, req_i.divisor[WLEN-1:0]} :
                    req_i.divisor;

  // unsigned word forms need zero extension for the magnitude
  assign dvd_ext = (attr.is_word && attr.is_unsigned) ?
                   {{(XLEN-WLEN){1'b0}}, req_i.dividend[WLEN-1:0]} : dvd_sext;
  assign dvs_ext = (attr.is_word && attr.is_unsigned) ?
                   {{(XLEN-WLEN){1'b0}}, req_i.divisor[WLEN-1:0]} : dvs_sext;

  assign dvd_neg = !attr.is_unsigned && dvd_sext[XLEN-1];
  assign dvs_neg = !attr.is_unsigned && dvs_sext[XLEN-1];

  // ==============================
  // special cases
  // ==============================
  assign min_neg = attr.is_word ? {{(XLEN-WLEN+1){1'b1}}, {(WLEN-1){1'b0}}} :
                                  {1'b1, {(XLEN-1){1'b0}}};

  assign div_zero = (dvs_ext == '0);
  assign overflow = !attr.is_unsigned && (dvd_sext == min_neg) && (&dvs_sext);

  always_comb begin
    prep_o.attr         = attr;
    prep_o.dividend_abs = dvd_neg ? -dvd_ext : dvd_ext;
    prep_o.divisor_abs  = dvs_neg ? -dvs_ext : dvs_ext;
    prep_o.q_neg        = dvd_neg ^ dvs_neg;
    prep_o.r_neg        = dvd_neg;
    prep_o.special      = div_zero || overflow;

    // results the ISA fixes for these cases
    if (div_zero) begin
      prep_o.special_value = attr.is_rem ? dvd_sext : '1;
    end else if (overflow) begin
      prep_o.special_value = attr.is_rem ? '0 : dvd_sext;   // quotient wraps to dividend
    end else begin
      prep_o.special_value = '0;
    end
  end

endmodule

//--- common/div_data_pkg.sv
// widths are fixed by RV64; word forms always use the low 32 bits of each operand
package div_data_pkg;
  import div_op_pkg::*;

  localparam int XLEN = 64;   // operand width
  localparam int WLEN = 32;   // word form width

  typedef struct packed {
    div_op_e         op;
    logic [XLEN-1:0] dividend;
    logic [XLEN-1:0] divisor;
  } div_req_t;

  // operands ready for the unsigned loop
  typedef struct packed {
    div_attr_t       attr;
    logic [XLEN-1:0] dividend_abs;
    logic [XLEN-1:0] divisor_abs;
    logic            q_neg;          // quotient sign to restore
    logic            r_neg;          // remainder follows dividend sign
    logic            special;        // zero divisor or overflow
    logic [XLEN-1:0] special_value;
  } div_prep_t;

  typedef struct packed {
    div_attr_t       attr;
    logic [XLEN-1:0] quotient_mag;
    logic [XLEN-1:0] remainder_mag;
    logic            q_neg;
    logic            r_neg;
    logic            special;
    logic [XLEN-1:0] special_value;
  } div_result_t;

endpackage

//--- common/div_op_pkg.sv
// opcode encoding is local to this unit and does not follow the RISC-V funct3 values
package div_op_pkg;

  // ==============================
  // operations
  // ==============================
  // bit 2 remainder, bit 1 unsigned, bit 0 word
  typedef enum logic [2:0] {
    OP_DIV   = 3'b000,
    OP_DIVW  = 3'b001,
    OP_DIVU  = 3'b010,
    OP_DIVUW = 3'b011,
    OP_REM   = 3'b100,
    OP_REMW  = 3'b101,
    OP_REMU  = 3'b110,
    OP_REMUW = 3'b111
  } div_op_e;

  typedef struct packed {
    logic is_rem;       // remainder instead of quotient
    logic is_unsigned;
    logic is_word;      // 32-bit form, result sign-extended
  } div_attr_t;

  // split opcode into flags
  function automatic div_attr_t decode_op(div_op_e op);
    div_attr_t attr;
    attr.is_rem      = op[2];
    attr.is_unsigned = op[1];
    attr.is_word     = op[0];
    return attr;
  endfunction

  // core FSM
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    ITERATE = 2'd1,
    DONE    = 2'd2
  } div_state_e;

endpackage
